/* common/cache_pkg.sv */
package cache_pkg;

    // Processor word and cache line
    localparam int word_width     = 16;
    localparam int line_width     = 64;
    localparam int words_per_line = line_width / word_width;

    // Organisation
    localparam int num_ways = 2;
    localparam int num_sets = 2;

    // Address split: tag 15..3, set 2, word offset 1..0
    localparam int offset_width = 2;
    localparam int set_bit      = 2;
    localparam int tag_lsb      = 3;
    localparam int tag_width    = word_width - tag_lsb;

    typedef logic [word_width-1:0]   word_t;
    typedef logic [line_width-1:0]   line_t;
    typedef logic [tag_width-1:0]    tag_t;
    typedef logic [offset_width-1:0] offset_t;

    // Size of one memory access
    typedef enum logic {
        size_word = 1'b0,
        size_line = 1'b1
    } mem_size_e;

    // Pending states mean a line write to memory is still outstanding
    typedef enum logic [2:0] {
        st_ready          = 3'd0,
        st_lookup         = 3'd1,
        st_mem_read       = 3'd2,
        st_mem_write      = 3'd3,
        st_ready_pending  = 3'd4,
        st_lookup_pending = 3'd5
    } cache_state_e;

endpackage

/* common/cache_ctrl_if.sv */
interface cache_ctrl_if import cache_pkg::*; ();

    // Lookup results and latched address fields
    logic    hit;
    logic    hit_way;
    logic    victim_way;
    tag_t    req_tag;
    logic    req_set;
    offset_t req_offset;

    // Controller strobes
    logic capture;
    logic touch;
    logic fill;
    logic merge;

    // Data store results
    word_t rd_word;
    line_t merged_line;

    modport tag (
        output hit, hit_way, victim_way, req_tag, req_set, req_offset,
        input  capture, touch, fill
    );

    modport ctrl (
        output capture, touch, fill, merge,
        input  hit, req_tag, req_set, req_offset, rd_word, merged_line
    );

    modport data (
        output rd_word, merged_line,
        input  hit, hit_way, victim_way, req_set, req_offset, capture, fill, merge
    );

endinterface

/* cache/cache_tag_store.sv */
module cache_tag_store import cache_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    input  word_t     i_addr,
    cache_ctrl_if.tag bus
);

    logic valid [num_sets][num_ways];
    tag_t tags  [num_sets][num_ways];
    // Per set, the least recently used way
    logic lru   [num_sets];

    logic way0_hit;
    logic way1_hit;

    // Request address, held for the whole access
    always_ff @(posedge clk) begin
        if (bus.capture) begin
            bus.req_tag    <= i_addr[word_width-1:tag_lsb];
            bus.req_set    <= i_addr[set_bit];
            bus.req_offset <= i_addr[offset_width-1:0];
        end
    end

    assign way0_hit = valid[bus.req_set][0] && (tags[bus.req_set][0] == bus.req_tag);
    assign way1_hit = valid[bus.req_set][1] && (tags[bus.req_set][1] == bus.req_tag);

    assign bus.hit     = way0_hit || way1_hit;
    assign bus.hit_way = !way0_hit;

    // Invalid way first, else the LRU way
    always_comb begin
        if (!valid[bus.req_set][0]) begin
            bus.victim_way = 1'b0;
        end else if (!valid[bus.req_set][1]) begin
            bus.victim_way = 1'b1;
        end else begin
            bus.victim_way = lru[bus.req_set];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int s = 0; s < num_sets; s++) begin
                lru[s] <= 1'b0;
                for (int w = 0; w < num_ways; w++) begin
                    valid[s][w] <= 1'b0;
                end
            end
        end else if (bus.fill) begin
            valid[bus.req_set][bus.victim_way] <= 1'b1;
            lru[bus.req_set]                   <= !bus.victim_way;
        end else if (bus.touch) begin
            // The other way becomes the one to replace
            lru[bus.req_set] <= !bus.hit_way;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.fill) begin
            tags[bus.req_set][bus.victim_way] <= bus.req_tag;
        end
    end

endmodule

/* cache/cache_data_store.sv */
module cache_data_store import cache_pkg::*; (
    input  logic       clk,
    input  word_t      i_wdata,
    input  line_t      i_mem_rdata,
    cache_ctrl_if.data bus
);

    line_t lines [num_sets][num_ways];
    line_t hit_line;
    word_t wdata_q;

    // Write word of the current request
    always_ff @(posedge clk) begin
        if (bus.capture) begin
            wdata_q <= i_wdata;
        end
    end

    assign hit_line    = lines[bus.req_set][bus.hit_way];
    assign bus.rd_word = hit_line[bus.req_offset*word_width +: word_width];

    // Hit line with the write word dropped in at the request offset
    always_comb begin
        bus.merged_line = hit_line;
        for (int w = 0; w < words_per_line; w++) begin
            if (offset_t'(w) == bus.req_offset) begin
                bus.merged_line[w*word_width +: word_width] = wdata_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.fill) begin
            lines[bus.req_set][bus.victim_way] <= i_mem_rdata;
        end else if (bus.merge && bus.hit) begin
            // Line stays valid and now matches what goes to memory
            lines[bus.req_set][bus.hit_way] <= bus.merged_line;
        end
    end

endmodule

/* cache/cache_controller.sv */
module cache_controller import cache_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       i_read,
    input  logic       i_write,
    output logic       o_ready,
    output logic       o_rvalid,
    output word_t      o_rdata,
    output logic       o_mem_read,
    output logic       o_mem_write,
    output word_t      o_mem_addr,
    output mem_size_e  o_mem_size,
    output line_t      o_mem_wdata,
    input  line_t      i_mem_rdata,
    input  logic       i_mem_ack,
    cache_ctrl_if.ctrl bus
);

    cache_state_e state;
    logic         req_write;

    logic  in_lookup;
    logic  in_lookup_pend;
    logic  rd_hit;
    logic  rd_miss;
    logic  wr_hit;
    logic  wr_miss;
    word_t line_addr;
    word_t word_addr;
    word_t req_wdata;

    assign o_ready     = (state == st_ready) || (state == st_ready_pending);
    assign bus.capture = o_ready && (i_read || i_write);

    assign in_lookup      = (state == st_lookup);
    assign in_lookup_pend = (state == st_lookup_pending);

    // A read hit is served even with a line write outstanding
    assign rd_hit  = (in_lookup || in_lookup_pend) && !req_write && bus.hit;
    assign rd_miss = in_lookup && !req_write && !bus.hit;
    assign wr_hit  = in_lookup && req_write && bus.hit;
    assign wr_miss = in_lookup && req_write && !bus.hit;

    assign bus.touch = rd_hit || wr_hit;
    assign bus.merge = wr_hit;
    assign bus.fill  = (state == st_mem_read) && i_mem_ack;

    assign line_addr = {bus.req_tag, bus.req_set, offset_t'(0)};
    assign word_addr = {bus.req_tag, bus.req_set, bus.req_offset};
    // Write word already sits in the merged line at its offset
    assign req_wdata = bus.merged_line[bus.req_offset*word_width +: word_width];

    // Read wins when both strobes are high
    always_ff @(posedge clk) begin
        if (bus.capture) begin
            req_write <= !i_read;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state       <= st_ready;
            o_rvalid    <= 1'b0;
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
        end else begin
            o_rvalid <= 1'b0;
            case (state)
                st_ready: begin
                    if (bus.capture) begin
                        state <= st_lookup;
                    end
                end
                st_ready_pending: begin
                    if (i_mem_ack) begin
                        o_mem_write <= 1'b0;
                        state       <= bus.capture ? st_lookup : st_ready;
                    end else if (bus.capture) begin
                        state <= st_lookup_pending;
                    end
                end
                st_lookup: begin
                    if (rd_hit) begin
                        o_rvalid <= 1'b1;
                        state    <= st_ready;
                    end else if (wr_hit) begin
                        // Processor continues while the line goes out
                        o_mem_write <= 1'b1;
                        state       <= st_ready_pending;
                    end else if (rd_miss) begin
                        o_mem_read <= 1'b1;
                        state      <= st_mem_read;
                    end else begin
                        o_mem_write <= 1'b1;
                        state       <= st_mem_write;
                    end
                end
                st_lookup_pending: begin
                    if (rd_hit) begin
                        o_rvalid <= 1'b1;
                        if (i_mem_ack) begin
                            o_mem_write <= 1'b0;
                            state       <= st_ready;
                        end else begin
                            state <= st_ready_pending;
                        end
                    end else if (i_mem_ack) begin
                        // Memory is free, look up again
                        o_mem_write <= 1'b0;
                        state       <= st_lookup;
                    end
                end
                st_mem_read: begin
                    if (i_mem_ack) begin
                        o_mem_read <= 1'b0;
                        o_rvalid   <= 1'b1;
                        state      <= st_ready;
                    end
                end
                st_mem_write: begin
                    if (i_mem_ack) begin
                        o_mem_write <= 1'b0;
                        state       <= st_ready;
                    end
                end
                default: state <= st_ready;
            endcase
        end
    end

    // Read data and memory request payload
    always_ff @(posedge clk) begin
        if (rd_hit) begin
            o_rdata <= bus.rd_word;
        end else if (bus.fill) begin
            o_rdata <= i_mem_rdata[bus.req_offset*word_width +: word_width];
        end

        if (rd_miss) begin
            o_mem_addr <= line_addr;
            o_mem_size <= size_line;
        end else if (wr_hit) begin
            o_mem_addr  <= line_addr;
            o_mem_size  <= size_line;
            o_mem_wdata <= bus.merged_line;
        end else if (wr_miss) begin
            // Single word at its own address, no allocate
            o_mem_addr  <= word_addr;
            o_mem_size  <= size_word;
            o_mem_wdata <= {{(line_width-word_width){1'b0}}, req_wdata};
        end
    end

endmodule

/* src/cache_top.sv */
module cache_top import cache_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    // Processor side
    input  logic      i_read,
    input  logic      i_write,
    input  word_t     i_addr,
    input  word_t     i_wdata,
    output logic      o_ready,
    output logic      o_rvalid,
    output word_t     o_rdata,
    // Memory side
    output logic      o_mem_read,
    output logic      o_mem_write,
    output word_t     o_mem_addr,
    output mem_size_e o_mem_size,
    output line_t     o_mem_wdata,
    input  line_t     i_mem_rdata,
    input  logic      i_mem_ack
);

    cache_ctrl_if bus_if ();

    cache_tag_store tag_store_i (
        .clk     (clk),
        .reset_n (reset_n),
        .i_addr  (i_addr),
        .bus     (bus_if.tag)
    );

    cache_data_store data_store_i (
        .clk         (clk),
        .i_wdata     (i_wdata),
        .i_mem_rdata (i_mem_rdata),
        .bus         (bus_if.data)
    );

    cache_controller controller_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_read      (i_read),
        .i_write     (i_write),
        .o_ready     (o_ready),
        .o_rvalid    (o_rvalid),
        .o_rdata     (o_rdata),
        .o_mem_read  (o_mem_read),
        .o_mem_write (o_mem_write),
        .o_mem_addr  (o_mem_addr),
        .o_mem_size  (o_mem_size),
        .o_mem_wdata (o_mem_wdata),
        .i_mem_rdata (i_mem_rdata),
        .i_mem_ack   (i_mem_ack),
        .bus         (bus_if.ctrl)
    );

endmodule

/* verif/cache_assert.sv */
module cache_assert import cache_pkg::*; (
    input logic  clk,
    input logic  reset_n,
    input logic  o_ready,
    input logic  o_rvalid,
    input logic  o_mem_read,
    input logic  o_mem_write,
    input word_t o_mem_addr,
    input logic  i_mem_ack
);

    // One memory access at a time
    assert property (@(posedge clk) disable iff (!reset_n)
        !(o_mem_read && o_mem_write))
        else $error("memory read and write strobes high together");

    // Address held until memory acknowledges
    assert property (@(posedge clk) disable iff (!reset_n)
        (o_mem_read || o_mem_write) && !i_mem_ack |=> $stable(o_mem_addr))
        else $error("memory address changed while waiting for ack");

    // Idle and ready straight out of reset
    assert property (@(posedge clk)
        !reset_n |=> !o_mem_read && !o_mem_write && o_ready && !o_rvalid)
        else $error("strobes or ready wrong after reset");

endmodule

bind cache_top cache_assert cache_assert_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .o_ready     (o_ready),
    .o_rvalid    (o_rvalid),
    .o_mem_read  (o_mem_read),
    .o_mem_write (o_mem_write),
    .o_mem_addr  (o_mem_addr),
    .i_mem_ack   (i_mem_ack)
);

/* verif/cache_tb.sv */
module cache_tb import cache_pkg::*; ();

    localparam int timeout_cycles = 100;

    logic      clk;
    logic      reset_n;
    logic      i_read;
    logic      i_write;
    word_t     i_addr;
    word_t     i_wdata;
    logic      o_ready;
    logic      o_rvalid;
    word_t     o_rdata;
    logic      o_mem_read;
    logic      o_mem_write;
    word_t     o_mem_addr;
    mem_size_e o_mem_size;
    line_t     o_mem_wdata;
    line_t     i_mem_rdata;
    logic      i_mem_ack;

    // Memory model and the last request it saw
    word_t       mem [0:65535];
    logic [31:0] mem_lfsr;
    int          mem_wait;
    logic        mem_busy;
    word_t       last_addr;
    mem_size_e   last_size;
    line_t       last_wdata;
    int          line_reads;
    int          line_writes;
    int          word_writes;

    // Reference model of the cache
    word_t       ref_mem [0:65535];
    logic        ref_valid [2][2];
    tag_t        ref_tag [2][2];
    logic        ref_lru [2];
    int          exp_line_reads;
    int          exp_line_writes;
    int          exp_word_writes;

    logic [31:0] stim_lfsr;
    int          checks;
    int          errors;

    cache_top cache_top_i (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic int draw_bits(inout logic [31:0] state, input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            state = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
            value = (value << 1) | int'(state[0]);
        end
        return value;
    endfunction

    // A different word at every address
    function automatic word_t fill_word(input word_t a);
        return {a[7:0], a[15:8]} ^ 16'h3c5a;
    endfunction

    always @(negedge clk) begin
        i_mem_ack = 1'b0;
        if (o_mem_read || o_mem_write) begin
            if (!mem_busy) begin
                // New request, answered after 1 to 4 cycles
                mem_busy   = 1'b1;
                mem_wait   = draw_bits(mem_lfsr, 2);
                last_addr  = o_mem_addr;
                last_size  = o_mem_size;
                last_wdata = o_mem_wdata;
            end
            if (mem_wait == 0) begin
                if (o_mem_read) begin
                    for (int w = 0; w < 4; w++) begin
                        i_mem_rdata[w*16 +: 16] = mem[word_t'(o_mem_addr + w)];
                    end
                    line_reads++;
                end else if (o_mem_size == size_line) begin
                    for (int w = 0; w < 4; w++) begin
                        mem[word_t'(o_mem_addr + w)] = o_mem_wdata[w*16 +: 16];
                    end
                    line_writes++;
                end else begin
                    mem[o_mem_addr] = o_mem_wdata[15:0];
                    word_writes++;
                end
                mem_busy  = 1'b0;
                i_mem_ack = 1'b1;
            end else begin
                mem_wait--;
            end
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_size(input string name, input mem_size_e got, input mem_size_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    task automatic abort_run(input string msg);
        errors++;
        $display("Timeout: %s", msg);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Regression failed");
        $finish;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!o_ready && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!o_ready) begin
            abort_run("o_ready stayed low");
        end
    endtask

    task automatic wait_mem_idle();
        int n;
        n = 0;
        while ((o_mem_read || o_mem_write || !o_ready) && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (o_mem_read || o_mem_write || !o_ready) begin
            abort_run("memory access never finished");
        end
    endtask

    task automatic issue_read(input word_t addr, output word_t data);
        int n;
        wait_ready();
        i_read = 1'b1;
        i_addr = addr;
        @(negedge clk);
        i_read = 1'b0;
        n = 0;
        while (!o_rvalid && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!o_rvalid) begin
            abort_run("no o_rvalid after a read");
        end
        data = o_rdata;
    endtask

    task automatic issue_write(input word_t addr, input word_t data);
        wait_ready();
        i_write = 1'b1;
        i_addr  = addr;
        i_wdata = data;
        @(negedge clk);
        i_write = 1'b0;
    endtask

    // Tag is bits 15 to 3, set is bit 2
    function automatic logic ref_hit(input word_t addr, output logic way);
        logic idx;
        idx = addr[2];
        way = ref_valid[idx][1] && (ref_tag[idx][1] == addr[15:3]);
        return way || (ref_valid[idx][0] && (ref_tag[idx][0] == addr[15:3]));
    endfunction

    task automatic ref_read(input word_t addr, output word_t data);
        logic idx;
        logic way;
        idx = addr[2];
        if (!ref_hit(addr, way)) begin
            // Invalid way first, else the least recently used one
            way = !ref_valid[idx][0] ? 1'b0 : (!ref_valid[idx][1] ? 1'b1 : ref_lru[idx]);
            ref_valid[idx][way] = 1'b1;
            ref_tag[idx][way]   = addr[15:3];
            exp_line_reads++;
        end
        ref_lru[idx] = !way;
        data = ref_mem[addr];
    endtask

    // Write-through, no allocate on a miss
    task automatic ref_write(input word_t addr, input word_t data);
        logic way;
        if (ref_hit(addr, way)) begin
            ref_lru[addr[2]] = !way;
            exp_line_writes++;
        end else begin
            exp_word_writes++;
        end
        ref_mem[addr] = data;
    endtask

    task automatic read_and_check(input word_t addr);
        word_t exp;
        word_t got;
        ref_read(addr, exp);
        issue_read(addr, got);
        check_word("o_rdata", got, exp);
    endtask

    task automatic write_word(input word_t addr, input word_t data);
        ref_write(addr, data);
        issue_write(addr, data);
    endtask

    task automatic test_reset_and_first_read();
        check_bit("o_ready", o_ready, 1'b1);
        check_bit("o_rvalid", o_rvalid, 1'b0);
        check_bit("o_mem_read", o_mem_read, 1'b0);
        check_bit("o_mem_write", o_mem_write, 1'b0);
        read_and_check(16'h0102);
        check_count("line_reads", line_reads, 1);
        check_word("o_mem_addr", last_addr, 16'h0100);
        check_size("o_mem_size", last_size, size_line);
    endtask

    task automatic test_read_hit();
        read_and_check(16'h0100);
        read_and_check(16'h0101);
        read_and_check(16'h0103);
        check_count("line_reads", line_reads, 1);
    endtask

    task automatic test_write_hit();
        write_word(16'h0101, 16'hbeef);
        wait_ready();
        if (!o_mem_write) begin
            report_error("no line write outstanding after a write hit");
        end
        read_and_check(16'h0101);
        wait_mem_idle();
        check_count("line_reads", line_reads, 1);
        check_count("line_writes", line_writes, 1);
        check_word("o_mem_addr", last_addr, 16'h0100);
        check_size("o_mem_size", last_size, size_line);
        check_line("o_mem_wdata", last_wdata,
                   {ref_mem[16'h0103], ref_mem[16'h0102], ref_mem[16'h0101], ref_mem[16'h0100]});
        // Read hit served while the second line write is outstanding
        write_word(16'h0102, 16'hcafe);
        read_and_check(16'h0102);
        if (!o_mem_write) begin
            report_error("read hit was not served while the line write was pending");
        end
        wait_mem_idle();
        check_count("line_reads", line_reads, 1);
        check_count("line_writes", line_writes, 2);
        check_line("o_mem_wdata", last_wdata,
                   {ref_mem[16'h0103], ref_mem[16'h0102], ref_mem[16'h0101], ref_mem[16'h0100]});
    endtask

    task automatic test_write_miss();
        write_word(16'h0205, 16'h1234);
        wait_mem_idle();
        check_count("word_writes", word_writes, 1);
        check_word("o_mem_addr", last_addr, 16'h0205);
        check_size("o_mem_size", last_size, size_word);
        check_line("o_mem_wdata", last_wdata, line_t'(16'h1234));
        read_and_check(16'h0205);
        check_count("line_reads", line_reads, 2);
        check_word("o_mem_addr", last_addr, 16'h0204);
    endtask

    task automatic test_replacement();
        int base;
        base = line_reads;
        read_and_check(16'h0400);
        read_and_check(16'h0800);
        read_and_check(16'h0400);
        check_count("line_reads", line_reads, base + 2);
        // 0800 is least recently used in set 0 now
        read_and_check(16'h0c00);
        read_and_check(16'h0400);
        check_count("line_reads", line_reads, base + 3);
        read_and_check(16'h0800);
        check_count("line_reads", line_reads, base + 4);
    endtask

    task automatic test_random();
        int bits;
        int data;
        for (int i = 0; i < 200; i++) begin
            bits = draw_bits(stim_lfsr, 6);
            if (bits[5]) begin
                data = draw_bits(stim_lfsr, 16);
                write_word(16'h1000 | word_t'(bits[4:0]), word_t'(data));
            end else begin
                read_and_check(16'h1000 | word_t'(bits[4:0]));
            end
        end
        wait_mem_idle();
        check_count("line_reads", line_reads, exp_line_reads);
        check_count("line_writes", line_writes, exp_line_writes);
        check_count("word_writes", word_writes, exp_word_writes);
    endtask

    initial begin
        reset_n     = 1'b0;
        i_read      = 1'b0;
        i_write     = 1'b0;
        i_addr      = '0;
        i_wdata     = '0;
        i_mem_rdata = '0;
        i_mem_ack   = 1'b0;
        stim_lfsr   = 32'h1ebb;
        mem_lfsr    = 32'h1ebb;
        mem_busy    = 1'b0;
        mem_wait    = 0;
        line_reads  = 0;
        line_writes = 0;
        word_writes = 0;
        exp_line_reads  = 0;
        exp_line_writes = 0;
        exp_word_writes = 0;
        checks = 0;
        errors = 0;
        for (int a = 0; a < 65536; a++) begin
            mem[word_t'(a)]     = fill_word(word_t'(a));
            ref_mem[word_t'(a)] = fill_word(word_t'(a));
        end
        for (int s = 0; s < 2; s++) begin
            ref_lru[s]      = 1'b0;
            ref_valid[s][0] = 1'b0;
            ref_valid[s][1] = 1'b0;
        end
        repeat (5) @(negedge clk);
        reset_n = 1'b1;
        test_reset_and_first_read();
        test_read_hit();
        test_write_hit();
        test_write_miss();
        test_replacement();
        test_random();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
common/cache_pkg.sv
common/cache_ctrl_if.sv
cache/cache_tag_store.sv
cache/cache_data_store.sv
cache/cache_controller.sv
src/cache_top.sv
verif/cache_assert.sv
verif/cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the cache testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module cache_tb \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
sim_ok=1
./obj_dir/Vcache_tb > sim.log 2>&1 || sim_ok=0
cat sim.log
grep -q "Regression failed" sim.log && exit 1
[ "$sim_ok" -eq 1 ] || { echo "Simulation ended abnormally"; exit 1; }
exit 0
